//--- hw/jtkcpu_pkg.sv
// shared types and constants of the sequencing core, referenced by scoped name from every module
`default_nettype none

package jtkcpu_pkg;

    // opcodes the core decodes, anything else runs as a one-byte nop
    typedef enum logic [7:0] {
        OP_NOP      = 8'h12,
        OP_LBRA     = 8'h16,
        OP_BCC_BASE = 8'h20,
        OP_JMP      = 8'h7E
    } op_e;

    // sequencer states
    typedef enum logic [2:0] {
        ST_FETCH_OP   = 3'd0,
        ST_WAIT_OP    = 3'd1,
        ST_FETCH_OPND = 3'd2,
        ST_WAIT_OPND  = 3'd3,
        ST_EXEC       = 3'd4,
        ST_DONE       = 3'd5
    } state_e;

    // program counter commands, applied at the next clock edge
    typedef enum logic [2:0] {
        PC_HOLD  = 3'd0,
        PC_INC   = 3'd1,
        PC_REL8  = 3'd2,
        PC_REL16 = 3'd3,
        PC_LOAD  = 3'd4
    } pc_cmd_e;

    // request side of the four-phase byte bus
    typedef struct packed {
        logic        req;
        logic [15:0] addr;
    } mem_req_t;

    // condition code bit positions, 6809 layout
    localparam int CC_E = 7;
    localparam int CC_F = 6;
    localparam int CC_H = 5;
    localparam int CC_I = 4;
    localparam int CC_N = 3;
    localparam int CC_Z = 2;
    localparam int CC_V = 1;
    localparam int CC_C = 0;

endpackage

`default_nettype wire

//--- hw/jtkcpu_ucode.sv
// instruction sequencer FSM, steps opcode and operand fetches and picks the pc command to execute
`timescale 1ns/1ps
`default_nettype none

module jtkcpu_ucode (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  halt,
    input  jtkcpu_pkg::op_e      op,
    input  wire                  taken,
    input  wire                  done,
    output logic                 start,
    output logic                 keep,
    output jtkcpu_pkg::pc_cmd_e  pc_cmd,
    output logic                 ni
);

    jtkcpu_pkg::state_e state;
    // operand bytes still to be read
    logic [1:0]         left;
    logic [7:0]         op_byte;
    logic               is_bcc;
    logic               is_long;
    logic [1:0]         need;

    assign op_byte = 8'(op);
    assign is_bcc  = (op_byte & 8'hF0) == 8'(jtkcpu_pkg::OP_BCC_BASE);
    assign is_long = (op == jtkcpu_pkg::OP_LBRA) || (op == jtkcpu_pkg::OP_JMP);

    // operand length by opcode class
    always_comb begin
        if (is_bcc) begin
            need = 2'd1;
        end else if (is_long) begin
            need = 2'd2;
        end else begin
            need = 2'd0;
        end
    end

    // pc moves past each byte as it arrives, then by the branch or jump at execute
    always_comb begin
        pc_cmd = jtkcpu_pkg::PC_HOLD;
        case (state)
            jtkcpu_pkg::ST_WAIT_OP,
            jtkcpu_pkg::ST_WAIT_OPND: begin
                if (done) begin
                    pc_cmd = jtkcpu_pkg::PC_INC;
                end
            end
            jtkcpu_pkg::ST_EXEC: begin
                if (is_bcc && taken) begin
                    pc_cmd = jtkcpu_pkg::PC_REL8;
                end else if (op == jtkcpu_pkg::OP_LBRA) begin
                    pc_cmd = jtkcpu_pkg::PC_REL16;
                end else if (op == jtkcpu_pkg::OP_JMP) begin
                    pc_cmd = jtkcpu_pkg::PC_LOAD;
                end
            end
            default: pc_cmd = jtkcpu_pkg::PC_HOLD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= jtkcpu_pkg::ST_FETCH_OP;
            left  <= 2'd0;
            start <= 1'b0;
            keep  <= 1'b0;
            ni    <= 1'b0;
        end else begin
            start <= 1'b0;
            ni    <= 1'b0;
            case (state)
                jtkcpu_pkg::ST_FETCH_OP: begin
                    // no new instruction while halted
                    if (!halt) begin
                        start <= 1'b1;
                        keep  <= 1'b0;
                        state <= jtkcpu_pkg::ST_WAIT_OP;
                    end
                end
                jtkcpu_pkg::ST_WAIT_OP: begin
                    if (done) begin
                        left  <= need;
                        state <= (need == 2'd0) ? jtkcpu_pkg::ST_EXEC
                                                : jtkcpu_pkg::ST_FETCH_OPND;
                    end
                end
                jtkcpu_pkg::ST_FETCH_OPND: begin
                    start <= 1'b1;
                    keep  <= 1'b1;
                    state <= jtkcpu_pkg::ST_WAIT_OPND;
                end
                jtkcpu_pkg::ST_WAIT_OPND: begin
                    if (done) begin
                        left  <= left - 2'd1;
                        state <= (left == 2'd1) ? jtkcpu_pkg::ST_EXEC
                                                : jtkcpu_pkg::ST_FETCH_OPND;
                    end
                end
                jtkcpu_pkg::ST_EXEC: begin
                    // retirement strobe lines up with the updated pc
                    ni    <= 1'b1;
                    state <= jtkcpu_pkg::ST_DONE;
                end
                jtkcpu_pkg::ST_DONE: begin
                    state <= jtkcpu_pkg::ST_FETCH_OP;
                end
                default: state <= jtkcpu_pkg::ST_FETCH_OP;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/jtkcpu_pc.sv
// program counter, holds, increments, adds a relative offset or loads an absolute target
`timescale 1ns/1ps
`default_nettype none

module jtkcpu_pc #(
    parameter logic [15:0] RESET_PC = 16'h0100
) (
    input  wire                  clk,
    input  wire                  rst,
    input  jtkcpu_pkg::pc_cmd_e  pc_cmd,
    input  wire [15:0]           operand,
    output logic [15:0]          pc
);

    logic [15:0] rel8;

    // short branch offset, sign extended from the low operand byte
    assign rel8 = {{8{operand[7]}}, operand[7:0]};

    // all sums wrap at 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            case (pc_cmd)
                jtkcpu_pkg::PC_HOLD: begin
                    pc <= pc;
                end
                jtkcpu_pkg::PC_INC: begin
                    pc <= pc + 16'd1;
                end
                jtkcpu_pkg::PC_REL8: begin
                    pc <= pc + rel8;
                end
                jtkcpu_pkg::PC_REL16: begin
                    pc <= pc + operand;
                end
                jtkcpu_pkg::PC_LOAD: begin
                    pc <= operand;
                end
                default: pc <= pc;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/jtkcpu_branch.sv
// branch condition evaluator, tests the low opcode nibble against the condition code byte
`timescale 1ns/1ps
`default_nettype none

module jtkcpu_branch (
    input  jtkcpu_pkg::op_e  op,
    input  wire [7:0]        cc,
    output logic             taken
);

    logic [7:0] op_byte;
    logic       n;
    logic       z;
    logic       v;
    logic       c;

    assign op_byte = 8'(op);
    assign n       = cc[jtkcpu_pkg::CC_N];
    assign z       = cc[jtkcpu_pkg::CC_Z];
    assign v       = cc[jtkcpu_pkg::CC_V];
    assign c       = cc[jtkcpu_pkg::CC_C];

    // odd nibbles are the inverse of the even one below them
    always_comb begin
        case (op_byte[3:0])
            4'h0: taken = 1'b1;
            4'h1: taken = 1'b0;
            4'h2: taken = !(c || z);
            4'h3: taken = c || z;
            4'h4: taken = !c;
            4'h5: taken = c;
            4'h6: taken = !z;
            4'h7: taken = z;
            4'h8: taken = !v;
            4'h9: taken = v;
            4'hA: taken = !n;
            4'hB: taken = n;
            // signed compares
            4'hC: taken = n == v;
            4'hD: taken = n != v;
            4'hE: taken = !z && (n == v);
            4'hF: taken = z || (n != v);
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/jtkcpu_membus.sv
// four-phase req/ack bus master, reads one byte per start into the opcode or operand register
`timescale 1ns/1ps
`default_nettype none

module jtkcpu_membus (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start,
    input  wire                   keep,
    input  wire [15:0]            pc,
    input  wire                   ack,
    input  wire [7:0]             rdata,
    output jtkcpu_pkg::mem_req_t  bus,
    output logic                  done,
    output jtkcpu_pkg::op_e       op,
    output logic [15:0]           operand
);

    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_REQ     = 2'd1,
        PH_RELEASE = 2'd2
    } phase_e;

    phase_e phase;
    logic   keep_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= PH_IDLE;
            bus.req <= 1'b0;
            done    <= 1'b0;
            keep_q  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (start) begin
                        bus.req <= 1'b1;
                        keep_q  <= keep;
                        phase   <= PH_REQ;
                    end
                end
                PH_REQ: begin
                    if (ack) begin
                        bus.req <= 1'b0;
                        phase   <= PH_RELEASE;
                    end
                end
                PH_RELEASE: begin
                    // the cycle is complete once the memory drops ack
                    if (!ack) begin
                        done  <= 1'b1;
                        phase <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // address and read data
    always_ff @(posedge clk) begin
        if (phase == PH_IDLE && start) begin
            bus.addr <= pc;
        end
        if (phase == PH_REQ && ack) begin
            if (keep_q) begin
                // big-endian operand, first byte ends up on top
                operand <= {operand[7:0], rdata};
            end else begin
                op      <= jtkcpu_pkg::op_e'(rdata);
                operand <= 16'd0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/jtkcpu_ctrl.sv
// top of the instruction sequencing core, wires the sequencer, pc, branch unit and bus master
`timescale 1ns/1ps
`default_nettype none

module jtkcpu_ctrl #(
    parameter logic [15:0] RESET_PC = 16'h0100
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   halt,
    input  wire [7:0]             cc,
    input  wire                   ack,
    input  wire [7:0]             rdata,
    output jtkcpu_pkg::mem_req_t  bus,
    output logic                  ni,
    output logic [15:0]           pc,
    output jtkcpu_pkg::op_e       op
);

    logic                 start;
    logic                 keep;
    logic                 done;
    logic                 taken;
    logic [15:0]          operand;
    jtkcpu_pkg::pc_cmd_e  pc_cmd;

    jtkcpu_ucode u_ucode (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .halt    ( halt    ),
        .op      ( op      ),
        .taken   ( taken   ),
        .done    ( done    ),
        .start   ( start   ),
        .keep    ( keep    ),
        .pc_cmd  ( pc_cmd  ),
        .ni      ( ni      )
    );

    jtkcpu_pc #(
        .RESET_PC ( RESET_PC )
    ) u_pc (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .pc_cmd  ( pc_cmd  ),
        .operand ( operand ),
        .pc      ( pc      )
    );

    jtkcpu_branch u_branch (
        .op      ( op      ),
        .cc      ( cc      ),
        .taken   ( taken   )
    );

    jtkcpu_membus u_membus (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .start   ( start   ),
        .keep    ( keep    ),
        .pc      ( pc      ),
        .ack     ( ack     ),
        .rdata   ( rdata   ),
        .bus     ( bus     ),
        .done    ( done    ),
        .op      ( op      ),
        .operand ( operand )
    );

endmodule

`default_nettype wire

//--- tb/jtkcpu_ctrl_tb.sv
// testbench for the sequencing core, random programs in a random memory against a reference model
`timescale 1ns/1ps
`default_nettype none

module jtkcpu_ctrl_tb;

    localparam logic [15:0] RESET_PC = 16'h0100;
    localparam int          N_INSTR  = 200;
    // forty cycles per instruction covers three slow byte reads plus the longest halt
    localparam int          LIMIT    = N_INSTR * 40;

    logic                  clk;
    logic                  rst;
    logic                  halt;
    logic [7:0]            cc;
    logic                  ack;
    logic [7:0]            rdata;
    jtkcpu_pkg::mem_req_t  bus;
    logic                  ni;
    logic [15:0]           pc;
    jtkcpu_pkg::op_e       op;

    logic [7:0]  mem [0:65535];
    // addresses of the requests seen since the last retirement
    logic [15:0] fetched [$];
    logic [15:0] exp_pc;

    int checks;
    int errors;
    int retired;
    int cycles;
    int idx;
    int stall;
    int ack_delay;
    int n_one;
    int n_taken;
    int n_not;
    int n_lbra;
    int n_jmp;
    int n_wrap;

    // values seen at the previous rising edge
    logic        rst_d;
    logic        rst_d2;
    logic        req_d;
    logic        ack_d;
    logic        halt_d1;
    logic        halt_d2;
    logic [15:0] addr_d;

    jtkcpu_ctrl #(
        .RESET_PC ( RESET_PC )
    ) jtkcpu_ctrl_inst (
        .clk   ( clk   ),
        .rst   ( rst   ),
        .halt  ( halt  ),
        .cc    ( cc    ),
        .ack   ( ack   ),
        .rdata ( rdata ),
        .bus   ( bus   ),
        .ni    ( ni    ),
        .pc    ( pc    ),
        .op    ( op    )
    );

    task automatic check(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("FAIL %0t: %s", $time, what);
        end
    endtask

    // even selectors hold the base test, the odd one above is its inverse
    function automatic bit branch_taken(input logic [3:0] sel, input logic [7:0] flags);
        bit n;
        bit z;
        bit v;
        bit c;
        bit base;
        n = flags[jtkcpu_pkg::CC_N];
        z = flags[jtkcpu_pkg::CC_Z];
        v = flags[jtkcpu_pkg::CC_V];
        c = flags[jtkcpu_pkg::CC_C];
        case (sel[3:1])
            3'd0: base = 1'b1;
            3'd1: base = !c && !z;
            3'd2: base = !c;
            3'd3: base = !z;
            3'd4: base = !v;
            3'd5: base = !n;
            3'd6: base = (n == v);
            default: base = !z && (n == v);
        endcase
        return sel[0] ? !base : base;
    endfunction

    function automatic logic [7:0] pick_opcode(input int sel);
        if (sel == 0) begin
            return 8'(jtkcpu_pkg::OP_NOP);
        end else if (sel == 1) begin
            return 8'(jtkcpu_pkg::OP_LBRA);
        end else if (sel == 2) begin
            return 8'(jtkcpu_pkg::OP_JMP);
        end
        return 8'(jtkcpu_pkg::OP_BCC_BASE) + 8'(sel - 3);
    endfunction

    // reference model of one instruction starting at address at
    task automatic predict(
        input  logic [15:0]      at,
        input  logic [7:0]       flags,
        output int               len,
        output logic [2:0][15:0] addrs,
        output logic [15:0]      next_pc,
        output logic [7:0]       opc,
        output bit               taken,
        output bit               wrap
    );
        logic [15:0] follow;
        logic [15:0] word;
        opc      = mem[at];
        addrs[0] = at;
        addrs[1] = at + 16'd1;
        addrs[2] = at + 16'd2;
        taken    = 1'b0;
        wrap     = 1'b0;
        if (opc[7:4] == 4'h2) begin
            len     = 2;
            follow  = at + 16'd2;
            word    = {{8{mem[addrs[1]][7]}}, mem[addrs[1]]};
            taken   = branch_taken(opc[3:0], flags);
            next_pc = taken ? follow + word : follow;
        end else if (opc == 8'(jtkcpu_pkg::OP_LBRA) || opc == 8'(jtkcpu_pkg::OP_JMP)) begin
            len     = 3;
            follow  = at + 16'd3;
            word    = {mem[addrs[1]], mem[addrs[2]]};
            if (opc == 8'(jtkcpu_pkg::OP_LBRA)) begin
                wrap    = ({1'b0, follow} + {1'b0, word}) > 17'h0FFFF;
                next_pc = follow + word;
            end else begin
                next_pc = word;
            end
        end else begin
            len     = 1;
            next_pc = at + 16'd1;
        end
    endtask

    task automatic score_retire();
        int               len;
        logic [2:0][15:0] addrs;
        logic [15:0]      next_pc;
        logic [7:0]       opc;
        bit               taken;
        bit               wrap;
        int               i;
        predict(exp_pc, cc, len, addrs, next_pc, opc, taken, wrap);
        check(fetched.size() == len, $sformatf("%0d reads for opcode %h at %h, expected %0d",
              fetched.size(), opc, exp_pc, len));
        for (i = 0; i < len && i < fetched.size(); i++) begin
            check(fetched[i] == addrs[i],
                  $sformatf("read %0d of opcode at %h went to %h, expected %h",
                            i, exp_pc, fetched[i], addrs[i]));
        end
        check(pc == next_pc, $sformatf("pc %h after opcode %h at %h cc %h, expected %h",
              pc, opc, exp_pc, cc, next_pc));
        check(8'(op) == opc, $sformatf("op port %h at retirement, expected %h", 8'(op), opc));
        if (len == 1) begin
            n_one++;
        end else if (len == 2 && taken) begin
            n_taken++;
        end else if (len == 2) begin
            n_not++;
        end else if (opc == 8'(jtkcpu_pkg::OP_LBRA)) begin
            n_lbra++;
        end else begin
            n_jmp++;
        end
        if (wrap) begin
            n_wrap++;
        end
        fetched.delete();
        exp_pc = next_pc;
        retired++;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // bus monitor, reads the values that settled before this edge
    always @(posedge clk) begin
        // reset values hold through reset and the first cycle after it
        if (rst_d === 1'b1 || rst_d2 === 1'b1) begin
            check(!bus.req && !ni && pc == RESET_PC, $sformatf("reset state req %b ni %b pc %h",
                  bus.req, ni, pc));
        end
        if (!rst && rst_d === 1'b0) begin
            if (bus.req && !req_d) begin
                check(!ack_d, "request raised while ack was still high");
                check(!halt_d2, "request raised while halt was high in the fetch state");
                fetched.push_back(bus.addr);
            end
            if (!bus.req && req_d) begin
                check(ack_d, "request dropped before ack was seen high");
            end
            if ((req_d || ack_d) && (bus.req || ack)) begin
                check(bus.addr == addr_d, $sformatf("address moved from %h to %h mid transfer",
                      addr_d, bus.addr));
            end
            if (ni) begin
                score_retire();
            end
        end
        rst_d2  = rst_d;
        rst_d   = rst;
        req_d   = bus.req;
        ack_d   = ack;
        halt_d2 = halt_d1;
        halt_d1 = halt;
        addr_d  = bus.addr;
    end

    // memory side of the four-phase handshake with random latency
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && bus.req) begin
                ack_delay = $urandom_range(0, 3);
                if (ack_delay > 0) begin
                    repeat (ack_delay) @(negedge clk);
                end
                rdata = mem[bus.addr];
                ack   = 1'b1;
                @(negedge clk);
                while (bus.req) begin
                    @(negedge clk);
                end
                ack_delay = $urandom_range(0, 3);
                if (ack_delay > 0) begin
                    repeat (ack_delay) @(negedge clk);
                end
                ack = 1'b0;
            end
        end
    end

    // halt stretch between instructions, new flags once the retired one is scored
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && ni) begin
                stall = $urandom_range(0, 5);
                halt  = (stall != 0);
                @(negedge clk);
                cc = 8'($urandom);
                if (stall > 1) begin
                    repeat (stall - 1) @(negedge clk);
                end
                halt = 1'b0;
            end
        end
    end

    initial begin
        rst     = 1'b1;
        halt    = 1'b0;
        cc      = 8'h00;
        ack     = 1'b0;
        rdata   = 8'h00;
        exp_pc  = RESET_PC;
        checks  = 0;
        errors  = 0;
        retired = 0;
        cycles  = 0;
        n_one   = 0;
        n_taken = 0;
        n_not   = 0;
        n_lbra  = 0;
        n_jmp   = 0;
        n_wrap  = 0;
        halt_d1 = 1'b0;
        halt_d2 = 1'b0;
        void'($urandom(22));
        // half known opcodes, half raw bytes that double as operands and unknown opcodes
        for (idx = 0; idx < 65536; idx++) begin
            if ($urandom_range(0, 1) == 1) begin
                mem[idx] = pick_opcode($urandom_range(0, 18));
            end else begin
                mem[idx] = 8'($urandom);
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (retired < N_INSTR && cycles < LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (retired < N_INSTR) begin
            errors++;
            $display("timeout: the core stopped retiring instructions, %0d of %0d done",
                     retired, N_INSTR);
        end
        $display("coverage: %0d one-byte, %0d short taken, %0d short not taken",
                 n_one, n_taken, n_not);
        $display("coverage: %0d lbra, %0d jmp, %0d wrapped", n_lbra, n_jmp, n_wrap);
        $display("summary: %0d instructions, %0d checks, %0d errors", retired, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- jtkcpu_ctrl.f
hw/jtkcpu_pkg.sv
hw/jtkcpu_ucode.sv
hw/jtkcpu_pc.sv
hw/jtkcpu_branch.sv
hw/jtkcpu_membus.sv
hw/jtkcpu_ctrl.sv
tb/jtkcpu_ctrl_tb.sv
